// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

typedef logic [31:0] word_t;
typedef logic [31:0] inst_addr_t;
typedef logic [4:0]  reg_addr_t;

// Primary opcodes
localparam logic [5:0] OP_SPECIAL = 6'b000000;
localparam logic [5:0] OP_ADDIU   = 6'b001001;
localparam logic [5:0] OP_ORI     = 6'b001101;
localparam logic [5:0] OP_LUI     = 6'b001111;

// Function codes under SPECIAL
localparam logic [5:0] FUNCT_ADDU = 6'b100001;
localparam logic [5:0] FUNCT_SUBU = 6'b100011;
localparam logic [5:0] FUNCT_AND  = 6'b100100;
localparam logic [5:0] FUNCT_OR   = 6'b100101;
localparam logic [5:0] FUNCT_XOR  = 6'b100110;
localparam logic [5:0] FUNCT_SLT  = 6'b101010;

// NOP must stay zero so a cleared slot is a bubble
typedef enum logic [2:0] {
	ALU_NOP,
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_LUI
} alu_op_t;

typedef struct packed {
	word_t inst1;
	word_t inst2;
} inst_pair_t;

typedef struct packed {
	logic      we;
	reg_addr_t waddr;
	word_t     wdata;
} reg_wr_req_t;

typedef struct packed {
	logic        valid;
	inst_addr_t  pc;
	alu_op_t     op;
	word_t       opnd1;
	word_t       opnd2;
	reg_wr_req_t wr;
} pipeline_data_t;

typedef struct packed {
	logic       we;
	inst_addr_t pc;
	reg_addr_t  waddr;
	word_t      wdata;
} wb_trace_t;

endpackage

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
	parameter cpu_pkg::inst_addr_t RESET_PC = 32'hbfc0_0000
)(
	input  logic                clk,
	input  logic                reset,
	output logic                inst_req,
	output cpu_pkg::inst_addr_t inst_addr,
	input  cpu_pkg::inst_pair_t inst_pair,
	input  logic                inst_busy,
	input  logic                inst2_taken,
	output cpu_pkg::inst_addr_t id_pc,
	output cpu_pkg::inst_pair_t id_inst_pair,
	output logic                id_valid
);

// Address presented in the previous cycle, reused after a refused pair
cpu_pkg::inst_addr_t fetch_pc;
logic accept;

assign accept = inst_req & ~inst_busy;

// A pair in ID decides the step
// Without lane b its word comes back as the next inst1
always_comb
begin
	if (id_valid)
	begin
		if (inst2_taken)
			inst_addr = id_pc + 32'd8;
		else
			inst_addr = id_pc + 32'd4;
	end
	else
	begin
		inst_addr = fetch_pc;
	end
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		inst_req <= 1'b0;
		fetch_pc <= RESET_PC;
		id_valid <= 1'b0;
	end
	else
	begin
		inst_req <= 1'b1;
		fetch_pc <= inst_addr;
		// Bubble into ID while the bus is busy
		id_valid <= accept;
	end
end

// IF/ID pair buffer
always_ff @(posedge clk)
begin
	if (accept)
	begin
		id_pc        <= inst_addr;
		id_inst_pair <= inst_pair;
	end
end

endmodule

// ==== verilog/regs.sv ====
`timescale 1ns/100ps

module regs(
	input  logic                 clk,
	input  logic                 reset,
	input  cpu_pkg::reg_wr_req_t wr1,
	input  cpu_pkg::reg_wr_req_t wr2,
	input  cpu_pkg::reg_addr_t   raddr1,
	input  cpu_pkg::reg_addr_t   raddr2,
	input  cpu_pkg::reg_addr_t   raddr3,
	input  cpu_pkg::reg_addr_t   raddr4,
	output cpu_pkg::word_t       rdata1,
	output cpu_pkg::word_t       rdata2,
	output cpu_pkg::word_t       rdata3,
	output cpu_pkg::word_t       rdata4
);

cpu_pkg::word_t gpr [0:31];

// Write-through, lane b is the younger write
function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t raddr);
	if (raddr == '0)
		return '0;
	if (wr2.we && wr2.waddr == raddr)
		return wr2.wdata;
	if (wr1.we && wr1.waddr == raddr)
		return wr1.wdata;
	return gpr[raddr];
endfunction

always_comb
begin
	rdata1 = read_port(raddr1);
	rdata2 = read_port(raddr2);
	rdata3 = read_port(raddr3);
	rdata4 = read_port(raddr4);
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < 32; i++)
			gpr[i] <= '0;
	end
	else
	begin
		if (wr1.we && wr1.waddr != '0)
			gpr[wr1.waddr] <= wr1.wdata;
		// Same target in both lanes keeps the lane b value
		if (wr2.we && wr2.waddr != '0)
			gpr[wr2.waddr] <= wr2.wdata;
	end
end

endmodule

// ==== verilog/cpu_id.sv ====
`timescale 1ns/100ps

module cpu_id(
	input  logic                    valid,
	input  cpu_pkg::inst_addr_t     pc,
	input  cpu_pkg::word_t          inst,
	output cpu_pkg::reg_addr_t      raddr1,
	output cpu_pkg::reg_addr_t      raddr2,
	input  cpu_pkg::word_t          rdata1,
	input  cpu_pkg::word_t          rdata2,
	input  cpu_pkg::reg_wr_req_t    ex_wr_a,
	input  cpu_pkg::reg_wr_req_t    ex_wr_b,
	input  cpu_pkg::reg_wr_req_t    wb_wr_a,
	input  cpu_pkg::reg_wr_req_t    wb_wr_b,
	output cpu_pkg::pipeline_data_t data
);

logic [5:0] opcode;
logic [5:0] funct;
logic [15:0] imm;
cpu_pkg::reg_addr_t rs, rt, rd;
cpu_pkg::reg_addr_t waddr;
cpu_pkg::word_t reg1, reg2, opnd2;
cpu_pkg::alu_op_t op;
logic we;

assign opcode = inst[31:26];
assign rs     = inst[25:21];
assign rt     = inst[20:16];
assign rd     = inst[15:11];
assign funct  = inst[5:0];
assign imm    = inst[15:0];

assign raddr1 = rs;
assign raddr2 = rt;

// Nearest producer wins, EX before WB and lane b before lane a
function automatic cpu_pkg::word_t forward(
	input cpu_pkg::reg_addr_t raddr,
	input cpu_pkg::word_t     rdata
);
	if (ex_wr_b.we && ex_wr_b.waddr == raddr)
		return ex_wr_b.wdata;
	if (ex_wr_a.we && ex_wr_a.waddr == raddr)
		return ex_wr_a.wdata;
	if (wb_wr_b.we && wb_wr_b.waddr == raddr)
		return wb_wr_b.wdata;
	if (wb_wr_a.we && wb_wr_a.waddr == raddr)
		return wb_wr_a.wdata;
	return rdata;
endfunction

always_comb
begin
	reg1 = forward(rs, rdata1);
	reg2 = forward(rt, rdata2);
end

always_comb
begin
	op    = cpu_pkg::ALU_NOP;
	waddr = rd;
	opnd2 = reg2;
	case (opcode)
		cpu_pkg::OP_SPECIAL:
		begin
			case (funct)
				cpu_pkg::FUNCT_ADDU: op = cpu_pkg::ALU_ADD;
				cpu_pkg::FUNCT_SUBU: op = cpu_pkg::ALU_SUB;
				cpu_pkg::FUNCT_AND:  op = cpu_pkg::ALU_AND;
				cpu_pkg::FUNCT_OR:   op = cpu_pkg::ALU_OR;
				cpu_pkg::FUNCT_XOR:  op = cpu_pkg::ALU_XOR;
				cpu_pkg::FUNCT_SLT:  op = cpu_pkg::ALU_SLT;
				default:             op = cpu_pkg::ALU_NOP;
			endcase
		end
		cpu_pkg::OP_ADDIU:
		begin
			op    = cpu_pkg::ALU_ADD;
			waddr = rt;
			opnd2 = {{16{imm[15]}}, imm};
		end
		cpu_pkg::OP_ORI:
		begin
			op    = cpu_pkg::ALU_OR;
			waddr = rt;
			opnd2 = {16'h0000, imm};
		end
		cpu_pkg::OP_LUI:
		begin
			op    = cpu_pkg::ALU_LUI;
			waddr = rt;
			opnd2 = {16'h0000, imm};
		end
		default:
			op = cpu_pkg::ALU_NOP;
	endcase
end

// Writes to $0 and unknown words retire silently
assign we = valid && op != cpu_pkg::ALU_NOP && waddr != '0;

always_comb
begin
	data.valid    = valid;
	data.pc       = pc;
	data.op       = we ? op : cpu_pkg::ALU_NOP;
	data.opnd1    = reg1;
	data.opnd2    = opnd2;
	data.wr.we    = we;
	data.wr.waddr = waddr;
	data.wr.wdata = '0;
end

endmodule

// ==== verilog/issue_ctrl.sv ====
`timescale 1ns/100ps

module issue_ctrl(
	input  cpu_pkg::pipeline_data_t data_a,
	input  cpu_pkg::pipeline_data_t data_b,
	input  cpu_pkg::reg_addr_t      raddr_b1,
	input  cpu_pkg::reg_addr_t      raddr_b2,
	output logic                    inst2_taken
);

logic a_writes_b_source;
logic raw_hazard;

// Lane a only writes nonzero registers
assign a_writes_b_source = data_a.wr.we &&
	(data_a.wr.waddr == raddr_b1 || data_a.wr.waddr == raddr_b2);

// A lane b with no result has nothing to get wrong
assign raw_hazard = a_writes_b_source && data_b.wr.we;

assign inst2_taken = data_b.valid && !raw_hazard;

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage(
	input  logic                    clk,
	input  logic                    reset,
	input  cpu_pkg::pipeline_data_t id_data_a,
	input  cpu_pkg::pipeline_data_t id_data_b,
	input  logic                    inst2_taken,
	output cpu_pkg::reg_wr_req_t    ex_wr_a,
	output cpu_pkg::reg_wr_req_t    ex_wr_b,
	output cpu_pkg::pipeline_data_t wb_data_a,
	output cpu_pkg::pipeline_data_t wb_data_b
);

cpu_pkg::pipeline_data_t ex_data_a, ex_data_b;
cpu_pkg::pipeline_data_t ex_done_a, ex_done_b;

function automatic cpu_pkg::reg_wr_req_t alu(input cpu_pkg::pipeline_data_t d);
	cpu_pkg::reg_wr_req_t r;
	cpu_pkg::word_t result;
	case (d.op)
		cpu_pkg::ALU_ADD: result = d.opnd1 + d.opnd2;
		cpu_pkg::ALU_SUB: result = d.opnd1 - d.opnd2;
		cpu_pkg::ALU_AND: result = d.opnd1 & d.opnd2;
		cpu_pkg::ALU_OR:  result = d.opnd1 | d.opnd2;
		cpu_pkg::ALU_XOR: result = d.opnd1 ^ d.opnd2;
		cpu_pkg::ALU_SLT: result = {31'b0, $signed(d.opnd1) < $signed(d.opnd2)};
		cpu_pkg::ALU_LUI: result = {d.opnd2[15:0], 16'h0000};
		default:          result = '0;
	endcase
	r.we    = d.valid & d.wr.we;
	r.waddr = d.wr.waddr;
	r.wdata = result;
	return r;
endfunction

// Results also feed forwarding in ID
assign ex_wr_a = alu(ex_data_a);
assign ex_wr_b = alu(ex_data_b);

always_comb
begin
	ex_done_a    = ex_data_a;
	ex_done_a.wr = ex_wr_a;
	ex_done_b    = ex_data_b;
	ex_done_b.wr = ex_wr_b;
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		ex_data_a <= '0;
		ex_data_b <= '0;
		wb_data_a <= '0;
		wb_data_b <= '0;
	end
	else
	begin
		ex_data_a <= id_data_a;
		// Held-back lane b enters as a bubble
		if (inst2_taken)
			ex_data_b <= id_data_b;
		else
			ex_data_b <= '0;
		wb_data_a <= ex_done_a;
		wb_data_b <= ex_done_b;
	end
end

endmodule

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/100ps

module writeback_stage(
	input  cpu_pkg::pipeline_data_t wb_data_a,
	input  cpu_pkg::pipeline_data_t wb_data_b,
	output cpu_pkg::reg_wr_req_t    reg_wr1,
	output cpu_pkg::reg_wr_req_t    reg_wr2,
	output cpu_pkg::wb_trace_t      wb_trace_a,
	output cpu_pkg::wb_trace_t      wb_trace_b
);

function automatic cpu_pkg::reg_wr_req_t commit(input cpu_pkg::pipeline_data_t d);
	cpu_pkg::reg_wr_req_t r;
	r.we    = d.valid & d.wr.we;
	r.waddr = d.wr.waddr;
	r.wdata = d.wr.wdata;
	return r;
endfunction

// One trace entry per register write
function automatic cpu_pkg::wb_trace_t trace(input cpu_pkg::pipeline_data_t d);
	cpu_pkg::wb_trace_t t;
	t.we    = d.valid & d.wr.we;
	t.pc    = d.pc;
	t.waddr = d.wr.waddr;
	t.wdata = d.wr.wdata;
	return t;
endfunction

assign reg_wr1    = commit(wb_data_a);
assign reg_wr2    = commit(wb_data_b);
assign wb_trace_a = trace(wb_data_a);
assign wb_trace_b = trace(wb_data_b);

endmodule

// ==== verilog/trivial_mips.sv ====
`timescale 1ns/100ps

module trivial_mips #(
	parameter cpu_pkg::inst_addr_t RESET_PC = 32'hbfc0_0000
)(
	input  logic                clk,
	input  logic                reset,
	output logic                inst_req,
	output cpu_pkg::inst_addr_t inst_addr,
	input  cpu_pkg::inst_pair_t inst_pair,
	input  logic                inst_busy,
	output cpu_pkg::wb_trace_t  wb_trace_a,
	output cpu_pkg::wb_trace_t  wb_trace_b
);

cpu_pkg::inst_addr_t id_pc, id_pc_b;
cpu_pkg::inst_pair_t id_inst_pair;
logic id_valid;
logic inst2_taken;

cpu_pkg::reg_addr_t reg_raddr1, reg_raddr2, reg_raddr3, reg_raddr4;
cpu_pkg::word_t reg_rdata1, reg_rdata2, reg_rdata3, reg_rdata4;
cpu_pkg::reg_wr_req_t reg_wr1, reg_wr2;

cpu_pkg::pipeline_data_t data_id_a, data_id_b;
cpu_pkg::pipeline_data_t data_wb_a, data_wb_b;
cpu_pkg::reg_wr_req_t ex_wr_a, ex_wr_b;

fetch_unit #(
	.RESET_PC(RESET_PC)
) fetch (
	.clk,
	.reset,
	.inst_req,
	.inst_addr,
	.inst_pair,
	.inst_busy,
	.inst2_taken,
	.id_pc,
	.id_inst_pair,
	.id_valid
);

regs general_regs(
	.clk,
	.reset,
	.wr1(reg_wr1),
	.wr2(reg_wr2),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.raddr3(reg_raddr3),
	.raddr4(reg_raddr4),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.rdata3(reg_rdata3),
	.rdata4(reg_rdata4)
);

assign id_pc_b = id_pc + 32'd4;

cpu_id lane_a(
	.valid(id_valid),
	.pc(id_pc),
	.inst(id_inst_pair.inst1),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.ex_wr_a,
	.ex_wr_b,
	.wb_wr_a(reg_wr1),
	.wb_wr_b(reg_wr2),
	.data(data_id_a)
);

cpu_id lane_b(
	.valid(id_valid),
	.pc(id_pc_b),
	.inst(id_inst_pair.inst2),
	.raddr1(reg_raddr3),
	.raddr2(reg_raddr4),
	.rdata1(reg_rdata3),
	.rdata2(reg_rdata4),
	.ex_wr_a,
	.ex_wr_b,
	.wb_wr_a(reg_wr1),
	.wb_wr_b(reg_wr2),
	.data(data_id_b)
);

issue_ctrl issue(
	.data_a(data_id_a),
	.data_b(data_id_b),
	.raddr_b1(reg_raddr3),
	.raddr_b2(reg_raddr4),
	.inst2_taken
);

ex_stage stage_ex(
	.clk,
	.reset,
	.id_data_a(data_id_a),
	.id_data_b(data_id_b),
	.inst2_taken,
	.ex_wr_a,
	.ex_wr_b,
	.wb_data_a(data_wb_a),
	.wb_data_b(data_wb_b)
);

writeback_stage stage_wb(
	.wb_data_a(data_wb_a),
	.wb_data_b(data_wb_b),
	.reg_wr1,
	.reg_wr2,
	.wb_trace_a,
	.wb_trace_b
);

endmodule

// ==== tb/trivial_mips_chk.sv ====
`timescale 1ns/100ps

module trivial_mips_chk(
	input logic                clk,
	input logic                reset,
	input logic                inst_req,
	input cpu_pkg::inst_addr_t inst_addr,
	input logic                inst_busy,
	input cpu_pkg::wb_trace_t  wb_trace_a,
	input cpu_pkg::wb_trace_t  wb_trace_b
);

// A refused request repeats the same address
addr_held: assert property (@(posedge clk) disable iff (reset)
	inst_req && inst_busy |=> $stable(inst_addr))
	else $error("inst_addr changed while the bus was busy");

// First reset edge still sees power-up state
quiet_reset: assert property (@(posedge clk)
	reset && $past(reset) |-> !inst_req && !wb_trace_a.we && !wb_trace_b.we)
	else $error("inst_req or trace write enable high during reset");

lane_order: assert property (@(posedge clk) disable iff (reset)
	wb_trace_a.we && wb_trace_b.we |-> wb_trace_b.pc > wb_trace_a.pc)
	else $error("lane b commit is not younger than lane a");

word_aligned: assert property (@(posedge clk) disable iff (reset)
	inst_req |-> inst_addr[1:0] == 2'b00)
	else $error("inst_addr is not word-aligned");

endmodule

// ==== tb/tb_trivial_mips.sv ====
`timescale 1ns/100ps

module tb_trivial_mips;

localparam cpu_pkg::inst_addr_t RESET_PC = 32'hbfc0_0000;
localparam int MEM_WORDS = 1024;
localparam int COMMIT_TARGET = 600;
localparam int CYCLE_LIMIT = 4 * MEM_WORDS + 100;

// One expected register write, with the registers its instruction reads
typedef struct packed {
	cpu_pkg::inst_addr_t pc;
	cpu_pkg::reg_addr_t  waddr;
	cpu_pkg::word_t      wdata;
	logic [31:0]         reads;
} commit_t;

logic clk;
logic reset;
logic inst_req;
cpu_pkg::inst_addr_t inst_addr;
cpu_pkg::inst_pair_t inst_pair;
logic inst_busy;
cpu_pkg::wb_trace_t wb_trace_a;
cpu_pkg::wb_trace_t wb_trace_b;

cpu_pkg::word_t imem [0:MEM_WORDS-1];
cpu_pkg::word_t model_gpr [0:31];
commit_t expected[$];
commit_t entry_a;
commit_t entry_b;
logic [31:0] rng_state;
int errors;
int checked;
int cycles;

trivial_mips #(
	.RESET_PC(RESET_PC)
) trivial_mips_i (
	.clk,
	.reset,
	.inst_req,
	.inst_addr,
	.inst_pair,
	.inst_busy,
	.wb_trace_a,
	.wb_trace_b
);

bind trivial_mips trivial_mips_chk chk_i(
	.clk(clk),
	.reset(reset),
	.inst_req(inst_req),
	.inst_addr(inst_addr),
	.inst_busy(inst_busy),
	.wb_trace_a(wb_trace_a),
	.wb_trace_b(wb_trace_b)
);

always #20 clk = ~clk;

// Pair of words at inst_addr, wrapping inside the memory
assign inst_pair = {imem[inst_addr[11:2]], imem[inst_addr[11:2] + 10'd1]};

function automatic logic [31:0] next_random();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// Registers 0 to 7 only, so results get reused a lot
function automatic cpu_pkg::word_t random_inst();
	logic [31:0] r;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [15:0] imm;
	r = next_random();
	rs = {2'b00, r[2:0]};
	rt = {2'b00, r[5:3]};
	rd = {2'b00, r[8:6]};
	imm = r[24:9];
	case (r[31:28])
		4'd0: return {6'h00, rs, rt, rd, 5'h00, 6'h21};
		4'd1: return {6'h00, rs, rt, rd, 5'h00, 6'h23};
		4'd2: return {6'h00, rs, rt, rd, 5'h00, 6'h24};
		4'd3: return {6'h00, rs, rt, rd, 5'h00, 6'h25};
		4'd4: return {6'h00, rs, rt, rd, 5'h00, 6'h26};
		4'd5, 4'd6: return {6'h00, rs, rt, rd, 5'h00, 6'h2a};
		4'd7, 4'd8, 4'd9: return {6'h09, rs, rt, imm};
		4'd10, 4'd11: return {6'h0d, rs, rt, imm};
		4'd12: return {6'h0f, rs, rt, imm};
		// LW and SLL lie outside the subset
		4'd13: return {6'h23, rs, rt, imm};
		4'd14: return {6'h00, rs, rt, rd, 5'h00, 6'h00};
		default: return {6'h00, rs, rt, rd, 5'h00, 6'h21};
	endcase
endfunction

// In-order ISA model, two passes over the memory
task automatic build_expected();
	cpu_pkg::inst_addr_t pc;
	cpu_pkg::word_t inst;
	cpu_pkg::word_t a;
	cpu_pkg::word_t b;
	cpu_pkg::word_t res;
	logic [4:0] dest;
	logic [15:0] imm;
	logic writes;
	logic [31:0] reads;
	commit_t c;
	pc = RESET_PC;
	for (int i = 0; i < 32; i++)
		model_gpr[i[4:0]] = '0;
	for (int n = 0; n < 2 * MEM_WORDS; n++)
	begin
		inst = imem[pc[11:2]];
		imm = inst[15:0];
		a = model_gpr[inst[25:21]];
		b = model_gpr[inst[20:16]];
		writes = 1'b1;
		dest = inst[20:16];
		reads = 32'd1 << inst[25:21];
		res = '0;
		case (inst[31:26])
			6'h00:
			begin
				dest = inst[15:11];
				reads = (32'd1 << inst[25:21]) | (32'd1 << inst[20:16]);
				case (inst[5:0])
					6'h21: res = a + b;
					6'h23: res = a - b;
					6'h24: res = a & b;
					6'h25: res = a | b;
					6'h26: res = a ^ b;
					6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			6'h09: res = a + {{16{imm[15]}}, imm};
			6'h0d: res = a | {16'h0000, imm};
			6'h0f:
			begin
				res = {imm, 16'h0000};
				reads = '0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && dest != 5'd0)
		begin
			model_gpr[dest] = res;
			c.pc = pc;
			c.waddr = dest;
			c.wdata = res;
			c.reads = reads;
			expected.push_back(c);
		end
		pc = pc + 32'd4;
	end
endtask

task automatic check_trace(input cpu_pkg::wb_trace_t t, input string name,
	output commit_t entry);
	entry = '0;
	if (!t.we)
		return;
	if (expected.size() == 0)
	begin
		errors++;
		$display("%0t: %s committed pc %h beyond the end of the model program",
			$time, name, t.pc);
		return;
	end
	entry = expected.pop_front();
	assert (t.pc == entry.pc)
	else
	begin
		errors++;
		$display("** Error at %0t: %s.pc = %h, expected %h", $time, name, t.pc, entry.pc);
	end
	assert (t.waddr == entry.waddr)
	else
	begin
		errors++;
		$display("** Error at %0t: %s.waddr = %0d, expected %0d",
			$time, name, t.waddr, entry.waddr);
	end
	assert (t.wdata == entry.wdata)
	else
	begin
		errors++;
		$display("** Error at %0t: %s.wdata = %h, expected %h",
			$time, name, t.wdata, entry.wdata);
	end
	checked++;
endtask

task automatic finish_run();
	$display("Commits checked: %0d, errors: %0d, cycles: %0d", checked, errors, cycles);
	if (errors == 0)
		$display("Testbench passed");
	else
		$display("Testbench failed");
	$finish;
endtask

initial
begin
	clk = 1'b0;
	reset = 1'b1;
	inst_busy = 1'b0;
	errors = 0;
	checked = 0;
	cycles = 0;
	rng_state = 32'hd82c_ef06;
	for (int i = 0; i < MEM_WORDS; i++)
		imem[i[9:0]] = random_inst();
	build_expected();
	repeat (4) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;
	while (checked < COMMIT_TARGET)
	begin
		@(negedge clk);
		check_trace(wb_trace_a, "wb_trace_a", entry_a);
		check_trace(wb_trace_b, "wb_trace_b", entry_b);
		// A pair that commits together must be independent
		if (wb_trace_a.we && wb_trace_b.we)
		begin
			assert (!entry_b.reads[entry_a.waddr])
			else
			begin
				errors++;
				$display("%0t: pc %h issued together with pc %h although it reads its result",
					$time, entry_b.pc, entry_a.pc);
			end
		end
		inst_busy = (next_random() % 32'd4) == 32'd0;
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			errors++;
			$display("Timeout after %0d cycles with %0d of %0d commits checked",
				cycles, checked, COMMIT_TARGET);
			break;
		end
	end
	finish_run();
end

endmodule

// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/regs.sv
verilog/cpu_id.sv
verilog/issue_ctrl.sv
verilog/ex_stage.sv
verilog/writeback_stage.sv
verilog/trivial_mips.sv
tb/trivial_mips_chk.sv
tb/tb_trivial_mips.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of tb_trivial_mips, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_trivial_mips -f compile.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
